//--- src/core_consts.svh
/*
 * Core-wide constants: data width, register index width,
 * reset fetch address and the bubble encoding
 */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define RESET_PC    32'h0000_0000

// ADDI x0, x0, 0
`define INSTR_NOP   32'h0000_0013

`endif

//--- src/rv_isa_pkg.sv
/*
 * RV32I encoding for the supported subset: opcode and funct
 * constants, and the instruction word as R, I, B and U views
 */
package rv_isa_pkg;

    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;

    localparam logic [2:0] F3_ADD_SUB  = 3'b000;
    localparam logic [2:0] F3_SLT      = 3'b010;
    localparam logic [2:0] F3_XOR      = 3'b100;
    localparam logic [2:0] F3_OR       = 3'b110;
    localparam logic [2:0] F3_AND      = 3'b111;
    localparam logic [2:0] F3_BEQ      = 3'b000;
    localparam logic [2:0] F3_BNE      = 3'b001;

    localparam logic [6:0] F7_BASE     = 7'b0000000;
    localparam logic [6:0] F7_ALT      = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_s;

    // Branch offset bits are scattered around the register fields
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_s;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_s;

    typedef union packed {
        r_type_s r;
        i_type_s i;
        b_type_s b;
        u_type_s u;
    } instr_u;

endpackage

//--- src/pipe_ctrl_pkg.sv
/*
 * Pipeline control types: ALU operation select and the
 * operand source chosen by the forwarding logic
 */
package pipe_ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        // LUI passes the immediate through
        ALU_PASS_B
    } alu_op_e;

    // Operand from the decode register or from the writeback register
    typedef enum logic {
        FWD_ID,
        FWD_WRB
    } fwd_sel_e;

endpackage

//--- src/fetch_stage.sv
/*
 * Fetch stage: program counter with redirect and gap hold,
 * and the fetch-to-decode register with flush and bubble insertion
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [31:0]      imem_rdata_i,
    input  logic             imem_valid_i,
    input  logic             branch_taken_i,
    input  logic [`XLEN-1:0] branch_target_i,
    input  logic             pipe_flush_i,
    output logic [`XLEN-1:0] imem_addr_o,
    output logic [31:0]      if_instr_o,
    output logic [`XLEN-1:0] if_pc_o,
    output logic             if_valid_o
);

    logic [`XLEN-1:0] pc_q;
    logic             fetch_ok;

    // A fetched word survives only if memory answered and no redirect is pending
    assign fetch_ok    = imem_valid_i && !pipe_flush_i;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q       <= `RESET_PC;
            if_valid_o <= 1'b0;
        end else begin
            if (branch_taken_i) begin
                pc_q <= branch_target_i;
            end else if (imem_valid_i) begin
                pc_q <= pc_q + `XLEN'd4;
            end
            if_valid_o <= fetch_ok;
        end
    end

    // Payload, bubble word on flush or gap
    always_ff @(posedge clk) begin
        if_instr_o <= fetch_ok ? imem_rdata_i : `INSTR_NOP;
        if_pc_o    <= pc_q;
    end

endmodule

//--- src/decode_stage.sv
/*
 * Decode stage: instruction decode and immediate generation,
 * register file with write-through reads, and the
 * decode-to-execute register with flush
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             if_instr_i,
    input  logic [`XLEN-1:0]        if_pc_i,
    input  logic                    if_valid_i,
    input  logic                    pipe_flush_i,
    input  logic                    wr_en_i,
    input  logic [`REG_ADDR_W-1:0]  wr_addr_i,
    input  logic [`XLEN-1:0]        wr_data_i,
    output logic                    id_valid_o,
    output pipe_ctrl_pkg::alu_op_e  id_alu_op_o,
    output logic                    id_use_imm_o,
    output logic                    id_is_branch_o,
    output logic                    id_branch_ne_o,
    output logic [`XLEN-1:0]        id_rs1_data_o,
    output logic [`XLEN-1:0]        id_rs2_data_o,
    output logic [`XLEN-1:0]        id_imm_o,
    output logic [`XLEN-1:0]        id_pc_o,
    output logic [`REG_ADDR_W-1:0]  id_rd_o,
    output logic [`REG_ADDR_W-1:0]  id_rs1_o,
    output logic [`REG_ADDR_W-1:0]  id_rs2_o
);
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    // x0 has no storage
    logic [`XLEN-1:0]       regs [1:(1 << `REG_ADDR_W) - 1];

    instr_u                 instr;
    logic                   supported;
    alu_op_e                alu_op;
    logic                   use_imm;
    logic                   is_branch;
    logic                   branch_ne;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    assign instr = if_instr_i;

    always_comb begin
        supported = 1'b0;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        imm       = '0;
        rd        = '0;
        rs1       = '0;
        rs2       = '0;
        case (instr.r.opcode)
            OPC_OP: begin
                rd        = instr.r.rd;
                rs1       = instr.r.rs1;
                rs2       = instr.r.rs2;
                supported = (instr.r.funct7 == F7_BASE);
                case (instr.r.funct3)
                    F3_ADD_SUB: begin
                        supported = supported || (instr.r.funct7 == F7_ALT);
                        alu_op    = (instr.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    end
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                rd        = instr.i.rd;
                rs1       = instr.i.rs1;
                use_imm   = 1'b1;
                imm       = {{(`XLEN - 12){instr.i.imm[11]}}, instr.i.imm};
                supported = 1'b1;
                case (instr.i.funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    supported = 1'b0;
                endcase
            end
            OPC_LUI: begin
                rd        = instr.u.rd;
                use_imm   = 1'b1;
                alu_op    = ALU_PASS_B;
                imm       = {instr.u.imm, 12'b0};
                supported = 1'b1;
            end
            OPC_BRANCH: begin
                rs1       = instr.b.rs1;
                rs2       = instr.b.rs2;
                is_branch = 1'b1;
                branch_ne = (instr.b.funct3 == F3_BNE);
                supported = (instr.b.funct3 == F3_BEQ) || (instr.b.funct3 == F3_BNE);
                imm       = {{(`XLEN - 12){instr.b.imm12}}, instr.b.imm11,
                             instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            default: supported = 1'b0;
        endcase
        // Unsupported words retire nothing
        if (!supported) begin
            rd = '0;
        end
    end

    // Same-cycle writeback is visible to the reader
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] idx);
        logic [`XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wr_en_i && (wr_addr_i == idx)) begin
            val = wr_data_i;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_reg(rs1);
        rs2_data = read_reg(rs2);
    end

    always_ff @(posedge clk) begin
        if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || pipe_flush_i) begin
            id_valid_o     <= 1'b0;
            id_is_branch_o <= 1'b0;
            id_rd_o        <= '0;
        end else begin
            id_valid_o     <= if_valid_i && supported;
            id_is_branch_o <= is_branch;
            id_rd_o        <= if_valid_i ? rd : '0;
        end
    end

    always_ff @(posedge clk) begin
        id_alu_op_o    <= alu_op;
        id_use_imm_o   <= use_imm;
        id_branch_ne_o <= branch_ne;
        id_rs1_data_o  <= rs1_data;
        id_rs2_data_o  <= rs2_data;
        id_imm_o       <= imm;
        id_pc_o        <= if_pc_i;
        id_rs1_o       <= rs1;
        id_rs2_o       <= rs2;
    end

endmodule

//--- src/execute_stage.sv
/*
 * Execute stage: forwarding muxes, ALU, branch compare and
 * target, and the execute-to-writeback register
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module execute_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    id_valid_i,
    input  pipe_ctrl_pkg::alu_op_e  id_alu_op_i,
    input  logic                    id_use_imm_i,
    input  logic                    id_is_branch_i,
    input  logic                    id_branch_ne_i,
    input  logic [`XLEN-1:0]        id_rs1_data_i,
    input  logic [`XLEN-1:0]        id_rs2_data_i,
    input  logic [`XLEN-1:0]        id_imm_i,
    input  logic [`XLEN-1:0]        id_pc_i,
    input  logic [`REG_ADDR_W-1:0]  id_rd_i,
    input  pipe_ctrl_pkg::fwd_sel_e fwd_rs1_sel_i,
    input  pipe_ctrl_pkg::fwd_sel_e fwd_rs2_sel_i,
    output logic                    branch_taken_o,
    output logic [`XLEN-1:0]        branch_target_o,
    output logic                    wrb_valid_o,
    output logic [`REG_ADDR_W-1:0]  wrb_rd_o,
    output logic [`XLEN-1:0]        wrb_data_o
);
    import pipe_ctrl_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic             operands_eq;

    // Producer one ahead sits in the writeback register
    assign op_a    = (fwd_rs1_sel_i == FWD_WRB) ? wrb_data_o : id_rs1_data_i;
    assign rs2_val = (fwd_rs2_sel_i == FWD_WRB) ? wrb_data_o : id_rs2_data_i;
    assign op_b    = id_use_imm_i ? id_imm_i : rs2_val;

    always_comb begin
        case (id_alu_op_i)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(`XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // BEQ and BNE compare the two register operands
    assign operands_eq     = (op_a == rs2_val);
    assign branch_taken_o  = id_valid_i && id_is_branch_i && (operands_eq ^ id_branch_ne_i);
    assign branch_target_o = id_pc_i + id_imm_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrb_valid_o <= 1'b0;
        end else begin
            wrb_valid_o <= id_valid_i && !id_is_branch_i && (id_rd_i != '0);
        end
    end

    always_ff @(posedge clk) begin
        wrb_rd_o   <= id_rd_i;
        wrb_data_o <= alu_res;
    end

endmodule

//--- src/forward_flush.sv
/*
 * Hazard unit: forward selects for the execute operands
 * and flush of the two younger stages on a taken branch
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module forward_flush (
    input  logic                    id_valid_i,
    input  logic [`REG_ADDR_W-1:0]  id_rs1_i,
    input  logic [`REG_ADDR_W-1:0]  id_rs2_i,
    input  logic                    wrb_valid_i,
    input  logic [`REG_ADDR_W-1:0]  wrb_rd_i,
    input  logic                    branch_taken_i,
    output pipe_ctrl_pkg::fwd_sel_e fwd_rs1_sel_o,
    output pipe_ctrl_pkg::fwd_sel_e fwd_rs2_sel_o,
    output logic                    pipe_flush_o
);
    import pipe_ctrl_pkg::*;

    logic hit_rs1;
    logic hit_rs2;

    // wrb_rd is never x0 while wrb_valid is high
    assign hit_rs1 = id_valid_i && wrb_valid_i && (id_rs1_i == wrb_rd_i);
    assign hit_rs2 = id_valid_i && wrb_valid_i && (id_rs2_i == wrb_rd_i);

    assign fwd_rs1_sel_o = hit_rs1 ? FWD_WRB : FWD_ID;
    assign fwd_rs2_sel_o = hit_rs2 ? FWD_WRB : FWD_ID;

    // Kills the words in the fetch-to-decode and decode-to-execute registers
    assign pipe_flush_o = branch_taken_i;

endmodule

//--- src/core_top.sv
/*
 * Core top level: fetch, decode, execute and the hazard unit,
 * with the instruction port and the retirement stream
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [31:0]            imem_rdata_i,
    input  logic                   imem_valid_i,
    output logic [`XLEN-1:0]       imem_addr_o,
    output logic                   wrb_valid_o,
    output logic [`REG_ADDR_W-1:0] wrb_rd_o,
    output logic [`XLEN-1:0]       wrb_data_o
);
    import pipe_ctrl_pkg::*;

    logic [31:0]            if_instr;
    logic [`XLEN-1:0]       if_pc;
    logic                   if_valid;

    logic                   id_valid;
    alu_op_e                id_alu_op;
    logic                   id_use_imm;
    logic                   id_is_branch;
    logic                   id_branch_ne;
    logic [`XLEN-1:0]       id_rs1_data;
    logic [`XLEN-1:0]       id_rs2_data;
    logic [`XLEN-1:0]       id_imm;
    logic [`XLEN-1:0]       id_pc;
    logic [`REG_ADDR_W-1:0] id_rd;
    logic [`REG_ADDR_W-1:0] id_rs1;
    logic [`REG_ADDR_W-1:0] id_rs2;

    logic                   branch_taken;
    logic [`XLEN-1:0]       branch_target;
    logic                   pipe_flush;
    fwd_sel_e               fwd_rs1_sel;
    fwd_sel_e               fwd_rs2_sel;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .imem_rdata_i    (imem_rdata_i),
        .imem_valid_i    (imem_valid_i),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .pipe_flush_i    (pipe_flush),
        .imem_addr_o     (imem_addr_o),
        .if_instr_o      (if_instr),
        .if_pc_o         (if_pc),
        .if_valid_o      (if_valid)
    );

    // Register file write comes straight from the retirement stream
    decode_stage u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .if_instr_i      (if_instr),
        .if_pc_i         (if_pc),
        .if_valid_i      (if_valid),
        .pipe_flush_i    (pipe_flush),
        .wr_en_i         (wrb_valid_o),
        .wr_addr_i       (wrb_rd_o),
        .wr_data_i       (wrb_data_o),
        .id_valid_o      (id_valid),
        .id_alu_op_o     (id_alu_op),
        .id_use_imm_o    (id_use_imm),
        .id_is_branch_o  (id_is_branch),
        .id_branch_ne_o  (id_branch_ne),
        .id_rs1_data_o   (id_rs1_data),
        .id_rs2_data_o   (id_rs2_data),
        .id_imm_o        (id_imm),
        .id_pc_o         (id_pc),
        .id_rd_o         (id_rd),
        .id_rs1_o        (id_rs1),
        .id_rs2_o        (id_rs2)
    );

    execute_stage u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_valid_i      (id_valid),
        .id_alu_op_i     (id_alu_op),
        .id_use_imm_i    (id_use_imm),
        .id_is_branch_i  (id_is_branch),
        .id_branch_ne_i  (id_branch_ne),
        .id_rs1_data_i   (id_rs1_data),
        .id_rs2_data_i   (id_rs2_data),
        .id_imm_i        (id_imm),
        .id_pc_i         (id_pc),
        .id_rd_i         (id_rd),
        .fwd_rs1_sel_i   (fwd_rs1_sel),
        .fwd_rs2_sel_i   (fwd_rs2_sel),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .wrb_valid_o     (wrb_valid_o),
        .wrb_rd_o        (wrb_rd_o),
        .wrb_data_o      (wrb_data_o)
    );

    forward_flush u_forward_flush (
        .id_valid_i      (id_valid),
        .id_rs1_i        (id_rs1),
        .id_rs2_i        (id_rs2),
        .wrb_valid_i     (wrb_valid_o),
        .wrb_rd_i        (wrb_rd_o),
        .branch_taken_i  (branch_taken),
        .fwd_rs1_sel_o   (fwd_rs1_sel),
        .fwd_rs2_sel_o   (fwd_rs2_sel),
        .pipe_flush_o    (pipe_flush)
    );

endmodule

//--- bench/core_checker.sv
/*
 * Retirement monitor: compares each writeback on the
 * retirement port against the expected list of the test
 */
`timescale 1ns/1ps

module core_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wrb_valid_i,
    input  logic [4:0]  wrb_rd_i,
    input  logic [31:0] wrb_data_i,
    output int          err_count_o,
    output logic        done_o
);

    localparam int MAX_EXP = 256;

    logic [4:0]  exp_rd [MAX_EXP];
    logic [31:0] exp_val [MAX_EXP];
    int          exp_n = 0;
    int          exp_idx = 0;

    initial err_count_o = 0;

    task automatic clear_expect();
        exp_n = 0;
    endtask

    task automatic load_expect(input logic [4:0] rd, input logic [31:0] val);
        exp_rd[exp_n]  = rd;
        exp_val[exp_n] = val;
        exp_n          = exp_n + 1;
    endtask

    assign done_o = (exp_idx >= exp_n);

    // Outputs come from flops, so the pre-edge values are stable here
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_idx <= 0;
        end else if (wrb_valid_i) begin
            if (exp_idx >= exp_n) begin
                $display("Unexpected extra writeback at %0t ns: x%0d <= %h",
                         $time, wrb_rd_i, wrb_data_i);
                err_count_o <= err_count_o + 1;
            end else begin
                if (wrb_rd_i !== exp_rd[exp_idx] || wrb_data_i !== exp_val[exp_idx]) begin
                    if (wrb_rd_i !== exp_rd[exp_idx]) begin
                        $display("** Error at %0t ns: wrb_rd_o got %0d expected %0d",
                                 $time, wrb_rd_i, exp_rd[exp_idx]);
                    end
                    if (wrb_data_i !== exp_val[exp_idx]) begin
                        $display("** Error at %0t ns: wrb_data_o got %h expected %h",
                                 $time, wrb_data_i, exp_val[exp_idx]);
                    end
                    err_count_o <= err_count_o + 1;
                end
                exp_idx <= exp_idx + 1;
            end
        end
    end

endmodule

//--- bench/core_tb.sv
/*
 * Core testbench: clock and reset, vector file reading,
 * instruction memory model with random gaps, watchdog
 * and the regression summary
 */
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb;

    localparam int MAX_TESTS  = 16;
    localparam int MAX_WORDS  = 512;
    localparam int MAX_EXP    = 512;
    localparam int IMEM_DEPTH = 64;
    localparam int IDLE_END   = 20;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] imem_rdata_i = `INSTR_NOP;
    logic        imem_valid_i = 1'b0;
    logic [31:0] imem_addr_o;
    logic        wrb_valid_o;
    logic [4:0]  wrb_rd_o;
    logic [31:0] wrb_data_o;
    int          chk_errors;
    logic        chk_done;

    string       test_name [MAX_TESTS];
    int          prog_start [MAX_TESTS];
    int          prog_len [MAX_TESTS];
    int          exp_start [MAX_TESTS];
    int          exp_len [MAX_TESTS];
    logic [31:0] prog_words [MAX_WORDS];
    logic [4:0]  exp_rd [MAX_EXP];
    logic [31:0] exp_val [MAX_EXP];
    logic [31:0] imem [IMEM_DEPTH];
    logic [31:0] lfsr = 32'h9d43;
    logic        gaps_on = 1'b0;
    int          n_tests = 0;
    int          n_words = 0;
    int          n_exp = 0;
    int          limit_cycles = 0;
    int          tb_errors = 0;
    int          passed = 0;
    int          failed = 0;

    core_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_rdata_i (imem_rdata_i),
        .imem_valid_i (imem_valid_i),
        .imem_addr_o  (imem_addr_o),
        .wrb_valid_o  (wrb_valid_o),
        .wrb_rd_o     (wrb_rd_o),
        .wrb_data_o   (wrb_data_o)
    );

    core_checker u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .wrb_valid_i  (wrb_valid_o),
        .wrb_rd_i     (wrb_rd_o),
        .wrb_data_i   (wrb_data_o),
        .err_count_o  (chk_errors),
        .done_o       (chk_done)
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // ADDI x31, x0 with an immediate folded from every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [11:0] imm;
        imm = addr[11:0] ^ addr[23:12] ^ {4'b0, addr[31:24]};
        return {imm, 5'd0, 3'b000, 5'd31, 7'b0010011};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] word;
        if (addr[31:2] < IMEM_DEPTH) begin
            word = imem[addr[7:2]];
        end else begin
            word = fill_word(addr);
        end
        return word;
    endfunction

    // Memory answers a delay after the edge and drops valid on about a quarter of cycles
    always @(posedge clk) begin
        logic b0;
        logic b1;
        #1;
        b0           = next_lfsr_bit();
        b1           = next_lfsr_bit();
        imem_rdata_i = fetch_word(imem_addr_o);
        imem_valid_i = !(gaps_on && b0 && b1);
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, tests did not finish", limit_cycles);
        $display("Regression failed");
        $finish;
    end

    task automatic read_vectors();
        int          fd;
        int          n;
        int          rd;
        logic [31:0] val;
        string       line;
        string       kw;
        string       name;
        fd = $fopen("bench/core_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file bench/core_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            kw   = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s", kw);
            if (n < 1 || kw.len() == 0 || kw[0] == "#") begin
                continue;
            end
            if (kw == "test") begin
                void'($sscanf(line, "%s %s", kw, name));
                test_name[n_tests]  = name;
                prog_start[n_tests] = n_words;
                prog_len[n_tests]   = 0;
                exp_start[n_tests]  = n_exp;
                exp_len[n_tests]    = 0;
                n_tests++;
            end else if (kw == "prog") begin
                void'($sscanf(line, "%s %h", kw, val));
                prog_words[n_words] = val;
                n_words++;
                prog_len[n_tests - 1]++;
            end else if (kw == "exp") begin
                void'($sscanf(line, "%s %d %h", kw, rd, val));
                exp_rd[n_exp]  = rd[4:0];
                exp_val[n_exp] = val;
                n_exp++;
                exp_len[n_tests - 1]++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t, input logic with_gaps);
        int    errs_before;
        int    idle;
        string mode;
        if (with_gaps) begin
            mode = "gaps";
        end else begin
            mode = "no gaps";
        end
        errs_before = chk_errors + tb_errors;
        @(posedge clk);
        #1 rst_n = 1'b0;
        gaps_on = with_gaps;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = fill_word(i * 4);
        end
        for (int j = 0; j < prog_len[t]; j++) begin
            imem[j] = prog_words[prog_start[t] + j];
        end
        u_chk.clear_expect();
        for (int k = 0; k < exp_len[t]; k++) begin
            u_chk.load_expect(exp_rd[exp_start[t] + k], exp_val[exp_start[t] + k]);
        end
        repeat (3) @(posedge clk);
        #1;
        if (wrb_valid_o !== 1'b0) begin
            $display("** Error at %0t ns: wrb_valid_o got %b expected 0", $time, wrb_valid_o);
            tb_errors++;
        end
        if (imem_addr_o !== `RESET_PC) begin
            $display("** Error at %0t ns: imem_addr_o got %h expected %h",
                     $time, imem_addr_o, `RESET_PC);
            tb_errors++;
        end
        rst_n = 1'b1;
        idle  = 0;
        while (idle < IDLE_END) begin
            @(posedge clk);
            #2;
            if (chk_done && !wrb_valid_o) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
        if (chk_errors + tb_errors == errs_before) begin
            $display("Test %s with %s: ok", test_name[t], mode);
            passed++;
        end else begin
            $display("Test %s with %s: FAILED with %0d errors", test_name[t], mode,
                     chk_errors + tb_errors - errs_before);
            failed++;
        end
    endtask

    initial begin
        read_vectors();
        if (n_tests == 0) begin
            $display("No tests were read from the vector file");
            tb_errors++;
        end
        // Each test runs once without gaps and once with them
        for (int t = 0; t < n_tests; t++) begin
            limit_cycles += 2 * (8 * prog_len[t] + 100);
        end
        for (int t = 0; t < n_tests; t++) begin
            run_test(t, 1'b0);
            run_test(t, 1'b1);
        end
        $display("Runs %0d, passed %0d, failed %0d", 2 * n_tests, passed, failed);
        if (failed == 0 && tb_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- core_top.f
+incdir+src
src/rv_isa_pkg.sv
src/pipe_ctrl_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/forward_flush.sv
src/core_top.sv
bench/core_checker.sv
bench/core_tb.sv

//--- Makefile
SIM     := verilator
TOP     := core_tb
FLIST   := core_top.f
FLAGS   := --binary --timing
LFLAGS  := --lint-only --timing
BIN     := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FLIST) --top-module $(TOP)

run: build
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

lint:
	$(SIM) $(LFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- bench/core_vectors.txt
# test <name>          starts a test
# prog <hex word>      next program word, from address zero upward
# exp <rd> <hex value> next expected writeback, in retirement order
test alu_basic
prog 00500093
prog FFD00113
prog 002081B3
prog 40208233
prog 0020F2B3
prog 0020E333
prog 0020C3B3
prog 00112433
prog 00700013
prog 123454B7
prog 6784E513
prog FFF54593
prog 0FF5F613
prog 00000063
exp 1 00000005
exp 2 FFFFFFFD
exp 3 00000002
exp 4 00000008
exp 5 00000005
exp 6 FFFFFFFD
exp 7 FFFFFFF8
exp 8 00000001
exp 9 12345000
exp 10 12345678
exp 11 EDCBA987
exp 12 00000087
test hazards
prog 00100093
prog 00108093
prog 00108133
prog 01008193
prog 40310233
prog 003242B3
prog 00000063
exp 1 00000001
exp 1 00000002
exp 2 00000004
exp 3 00000012
exp 4 FFFFFFF2
exp 5 FFFFFFE0
test branches
prog 00300093
prog 00300113
prog 00209463
prog 00700193
prog 00208663
prog 00100213
prog 00100293
prog 00900313
prog 00031463
prog 00100393
prog FF730413
prog 00000063
exp 1 00000003
exp 2 00000003
exp 3 00000007
exp 6 00000009
exp 8 00000000
